/* hw/mci_pkg.sv */
package mci_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int USER_WIDTH = 32;
    localparam int KB         = 1024;

    ////////////////////////////////////////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////////////////////////////////////////
    // Register window, fixed 4 KB
    localparam logic [ADDR_WIDTH-1:0] REG_START_ADDR = 32'h0000_0000;
    localparam int                    REG_SIZE_BYTES = 4 * KB;

    // Memory windows, sizes set at the top level
    localparam logic [ADDR_WIDTH-1:0] MBOX_START_ADDR = 32'h0040_0000;
    localparam logic [ADDR_WIDTH-1:0] SRAM_START_ADDR = 32'h00C0_0000;

    ////////////////////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [DATA_WIDTH-1:0] HW_ID_VALUE = 32'h4D43_4901;

    // Byte offset bits inside the register window
    localparam int REG_OFS_WIDTH = $clog2(REG_SIZE_BYTES);

    localparam logic [REG_OFS_WIDTH-1:0] REG_HW_ID      = 12'h000;
    localparam logic [REG_OFS_WIDTH-1:0] REG_SRAM_LOCK  = 12'h004;
    localparam logic [REG_OFS_WIDTH-1:0] REG_SCRATCH0   = 12'h008;
    localparam logic [REG_OFS_WIDTH-1:0] REG_SCRATCH1   = 12'h00C;
    localparam logic [REG_OFS_WIDTH-1:0] REG_MISS_COUNT = 12'h010;

    // Decoded request target
    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_REG,
        TGT_MBOX,
        TGT_SRAM
    } target_e;

    // Memory read sequence
    typedef enum logic {
        MEM_IDLE,
        MEM_READ_DATA
    } mem_state_e;

endpackage

/* hw/mci_sub_decode.sv */
module mci_sub_decode #(
    parameter int MBOX_SIZE_KB = 16,
    parameter int SRAM_SIZE_KB = 64
) (
    input  logic                            clk,
    input  logic                            arst_n,

    // SoC request port
    input  logic                            soc_dv,
    input  logic [mci_pkg::ADDR_WIDTH-1:0]  soc_addr,
    input  logic                            soc_write,
    input  logic [mci_pkg::DATA_WIDTH-1:0]  soc_wdata,
    input  logic [mci_pkg::USER_WIDTH-1:0]  soc_user,
    output logic [mci_pkg::DATA_WIDTH-1:0]  soc_rdata,
    output logic                            soc_hold,
    output logic                            soc_error,

    // Privileged user straps
    input  logic [mci_pkg::USER_WIDTH-1:0]  strap_mcu_lsu_axi_user,
    input  logic [mci_pkg::USER_WIDTH-1:0]  strap_mcu_ifu_axi_user,
    input  logic [mci_pkg::USER_WIDTH-1:0]  strap_mcu_sram_config_axi_user,
    input  logic [mci_pkg::USER_WIDTH-1:0]  strap_mci_soc_config_axi_user,

    // Target responses
    input  logic [mci_pkg::DATA_WIDTH-1:0]  reg_rdata,
    input  logic                            reg_hold,
    input  logic                            reg_error,
    input  logic [mci_pkg::DATA_WIDTH-1:0]  mbox_rdata,
    input  logic                            mbox_hold,
    input  logic                            mbox_error,
    input  logic [mci_pkg::DATA_WIDTH-1:0]  sram_rdata,
    input  logic                            sram_hold,
    input  logic                            sram_error,

    // Target requests
    output logic                            reg_dv,
    output logic                            mbox_dv,
    output logic                            sram_dv,
    output logic [mci_pkg::ADDR_WIDTH-1:0]  tgt_addr,
    output logic                            tgt_write,
    output logic [mci_pkg::DATA_WIDTH-1:0]  tgt_wdata,
    output logic                            reg_wr_priv,
    output logic                            mbox_wr_priv,
    output logic                            sram_wr_priv,
    output logic                            req_miss,

    // Privilege flags
    output logic                            axi_mcu_req,
    output logic                            axi_mci_soc_config_req,
    output logic                            axi_mcu_sram_config_req
);

    // Inclusive window ends
    localparam logic [mci_pkg::ADDR_WIDTH-1:0] REG_END_ADDR =
        mci_pkg::REG_START_ADDR + mci_pkg::REG_SIZE_BYTES - 1;
    localparam logic [mci_pkg::ADDR_WIDTH-1:0] MBOX_END_ADDR =
        mci_pkg::MBOX_START_ADDR + MBOX_SIZE_KB * mci_pkg::KB - 1;
    localparam logic [mci_pkg::ADDR_WIDTH-1:0] SRAM_END_ADDR =
        mci_pkg::SRAM_START_ADDR + SRAM_SIZE_KB * mci_pkg::KB - 1;

    mci_pkg::target_e               tgt;
    mci_pkg::target_e               sel;
    logic [mci_pkg::ADDR_WIDTH-1:0] tgt_base;
    logic                           soc_config_disable;
    logic                           soc_config_force;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        tgt = mci_pkg::TGT_NONE;
        if (soc_addr inside {[mci_pkg::REG_START_ADDR:REG_END_ADDR]}) begin
            tgt = mci_pkg::TGT_REG;
        end else if (soc_addr inside {[mci_pkg::MBOX_START_ADDR:MBOX_END_ADDR]}) begin
            tgt = mci_pkg::TGT_MBOX;
        end else if (soc_addr inside {[mci_pkg::SRAM_START_ADDR:SRAM_END_ADDR]}) begin
            tgt = mci_pkg::TGT_SRAM;
        end
    end

    // Only a live request selects a target
    assign sel = soc_dv ? tgt : mci_pkg::TGT_NONE;

    assign reg_dv   = (sel == mci_pkg::TGT_REG);
    assign mbox_dv  = (sel == mci_pkg::TGT_MBOX);
    assign sram_dv  = (sel == mci_pkg::TGT_SRAM);
    // Misses are counted by the register block
    assign req_miss = soc_dv & (tgt == mci_pkg::TGT_NONE);

    ////////////////////////////////////////////////////////////////////////////
    // Request fan-out and response mux
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        tgt_base  = mci_pkg::REG_START_ADDR;
        soc_rdata = '0;
        soc_hold  = 1'b0;
        soc_error = 1'b0;
        case (sel)
            mci_pkg::TGT_REG: begin
                soc_rdata = reg_rdata;
                soc_hold  = reg_hold;
                soc_error = reg_error;
            end
            mci_pkg::TGT_MBOX: begin
                tgt_base  = mci_pkg::MBOX_START_ADDR;
                soc_rdata = mbox_rdata;
                soc_hold  = mbox_hold;
                soc_error = mbox_error;
            end
            mci_pkg::TGT_SRAM: begin
                tgt_base  = mci_pkg::SRAM_START_ADDR;
                soc_rdata = sram_rdata;
                soc_hold  = sram_hold;
                soc_error = sram_error;
            end
            default: begin
            end
        endcase
    end

    // Offset within the selected window
    assign tgt_addr  = soc_addr - tgt_base;
    assign tgt_write = soc_write;
    assign tgt_wdata = soc_wdata;

    ////////////////////////////////////////////////////////////////////////////
    // Privileged user detect
    ////////////////////////////////////////////////////////////////////////////
    // All zeros turns the SoC-config user off and all ones grants it to everyone
    assign soc_config_disable = ~|strap_mci_soc_config_axi_user;
    assign soc_config_force   = &strap_mci_soc_config_axi_user;

    assign axi_mci_soc_config_req = soc_dv &
        (((soc_user == strap_mci_soc_config_axi_user) & ~soc_config_disable) |
         soc_config_force);
    assign axi_mcu_req = soc_dv & ((soc_user == strap_mcu_lsu_axi_user) |
                                   (soc_user == strap_mcu_ifu_axi_user));
    assign axi_mcu_sram_config_req = soc_dv & (soc_user == strap_mcu_sram_config_axi_user);

    // Per-target write privilege
    assign reg_wr_priv  = axi_mci_soc_config_req;
    assign mbox_wr_priv = axi_mcu_req | axi_mci_soc_config_req;
    assign sram_wr_priv = axi_mcu_req | axi_mcu_sram_config_req;

    ////////////////////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////////////////////
    // Offset handed to a target stays inside its window
    tgt_ofs_in_window_a: assert property (@(posedge clk) disable iff (!arst_n)
        (!reg_dv  || (tgt_addr < mci_pkg::REG_SIZE_BYTES)) &&
        (!mbox_dv || (tgt_addr < MBOX_SIZE_KB * mci_pkg::KB)) &&
        (!sram_dv || (tgt_addr < SRAM_SIZE_KB * mci_pkg::KB)));

    // A miss answers with zero data and no hold or error
    miss_quiet_rsp_a: assert property (@(posedge clk) disable iff (!arst_n)
        req_miss |-> (soc_rdata == '0) && !soc_hold && !soc_error);

    // Windows in ascending order without overlap
    initial begin
        win_order_a: assert (REG_END_ADDR < mci_pkg::MBOX_START_ADDR &&
                             MBOX_END_ADDR < mci_pkg::SRAM_START_ADDR);
    end

endmodule

/* hw/mci_ctrl_regs.sv */
module mci_ctrl_regs (
    input  logic                            clk,
    input  logic                            arst_n,

    // Request from decoder
    input  logic                            dv,
    input  logic [mci_pkg::ADDR_WIDTH-1:0]  addr,
    input  logic                            write,
    input  logic [mci_pkg::DATA_WIDTH-1:0]  wdata,
    input  logic                            wr_priv,
    input  logic                            req_miss,

    // Response
    output logic [mci_pkg::DATA_WIDTH-1:0]  rdata,
    output logic                            hold,
    output logic                            error,

    // Lock to the SRAM
    output logic                            sram_wr_lock
);

    logic [mci_pkg::REG_OFS_WIDTH-1:0] ofs;
    logic                              is_rw;
    logic                              is_ro;
    logic                              wr_en;
    logic                              sram_lock_q;
    logic [mci_pkg::DATA_WIDTH-1:0]    scratch0_q;
    logic [mci_pkg::DATA_WIDTH-1:0]    scratch1_q;
    logic [mci_pkg::DATA_WIDTH-1:0]    miss_count_q;

    // Window offset with upper bits stripped by the decoder
    assign ofs = addr[mci_pkg::REG_OFS_WIDTH-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Read mux and offset classify
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        rdata = '0;
        is_rw = 1'b0;
        is_ro = 1'b0;
        case (ofs)
            mci_pkg::REG_HW_ID: begin
                rdata = mci_pkg::HW_ID_VALUE;
                is_ro = 1'b1;
            end
            mci_pkg::REG_SRAM_LOCK: begin
                // Only bit 0 implemented
                rdata = {{(mci_pkg::DATA_WIDTH-1){1'b0}}, sram_lock_q};
                is_rw = 1'b1;
            end
            mci_pkg::REG_SCRATCH0: begin
                rdata = scratch0_q;
                is_rw = 1'b1;
            end
            mci_pkg::REG_SCRATCH1: begin
                rdata = scratch1_q;
                is_rw = 1'b1;
            end
            mci_pkg::REG_MISS_COUNT: begin
                rdata = miss_count_q;
                is_ro = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Write lands only on a writable register with privilege
    assign wr_en = dv & write & wr_priv & is_rw;

    // Unmapped, read-only target or missing privilege
    assign error = dv & (~(is_rw | is_ro) | (write & (~wr_priv | is_ro)));

    // Always single cycle
    assign hold         = 1'b0;
    assign sram_wr_lock = sram_lock_q;

    ////////////////////////////////////////////////////////////////////////////
    // Register state
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sram_lock_q <= 1'b0;
            scratch0_q  <= '0;
            scratch1_q  <= '0;
        end else if (wr_en) begin
            case (ofs)
                mci_pkg::REG_SRAM_LOCK: sram_lock_q <= wdata[0];
                mci_pkg::REG_SCRATCH0:  scratch0_q  <= wdata;
                mci_pkg::REG_SCRATCH1:  scratch1_q  <= wdata;
                default: begin
                end
            endcase
        end
    end

    // Miss counter sticks at all ones
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            miss_count_q <= '0;
        end else if (req_miss && !(&miss_count_q)) begin
            miss_count_q <= miss_count_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////////////////////
    // A rejected write leaves every register as it was
    err_wr_no_effect_a: assert property (@(posedge clk) disable iff (!arst_n)
        (error && write) |=>
            ($stable(sram_lock_q) && $stable(scratch0_q) && $stable(scratch1_q)));

endmodule

/* hw/mci_sub_mem.sv */
module mci_sub_mem #(
    parameter int DEPTH_WORDS = 4096,
    // Honor wr_lock only when set
    parameter bit LOCKABLE    = 1'b0
) (
    input  logic                            clk,
    input  logic                            arst_n,

    // Request from decoder
    input  logic                            dv,
    input  logic [mci_pkg::ADDR_WIDTH-1:0]  addr,
    input  logic                            write,
    input  logic [mci_pkg::DATA_WIDTH-1:0]  wdata,
    input  logic                            wr_priv,
    input  logic                            wr_lock,

    // Response
    output logic [mci_pkg::DATA_WIDTH-1:0]  rdata,
    output logic                            hold,
    output logic                            error
);

    localparam int IDX_WIDTH = $clog2(DEPTH_WORDS);

    logic [mci_pkg::DATA_WIDTH-1:0] mem [DEPTH_WORDS];
    logic [mci_pkg::DATA_WIDTH-1:0] rd_data_q;
    logic [IDX_WIDTH-1:0]           idx;
    logic                           wr_allow;
    logic                           rd_start;
    mci_pkg::mem_state_e            state_q;
    mci_pkg::mem_state_e            state_d;

    // Word index from byte offset
    assign idx = addr[IDX_WIDTH+1:2];

    assign wr_allow = wr_priv & ~(LOCKABLE & wr_lock);
    assign rd_start = dv & ~write & (state_q == mci_pkg::MEM_IDLE);

    ////////////////////////////////////////////////////////////////////////////
    // Read sequencer
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            mci_pkg::MEM_IDLE: begin
                if (rd_start) begin
                    state_d = mci_pkg::MEM_READ_DATA;
                end
            end
            // Completion cycle, data already registered
            mci_pkg::MEM_READ_DATA: state_d = mci_pkg::MEM_IDLE;
            default:                state_d = mci_pkg::MEM_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= mci_pkg::MEM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Array and read data register
    always_ff @(posedge clk) begin
        if (dv && write && wr_allow) begin
            mem[idx] <= wdata;
        end
        if (rd_start) begin
            rd_data_q <= mem[idx];
        end
    end

    // Hold first read cycle only, rejected writes error
    assign hold  = rd_start;
    assign error = dv & write & ~wr_allow;
    assign rdata = rd_data_q;

    no_back_to_back_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        hold |=> !hold);

endmodule

/* hw/mci_sub_top.sv */
module mci_sub_top #(
    parameter int MBOX_SIZE_KB = 16,
    parameter int SRAM_SIZE_KB = 64
) (
    input  logic                            clk,
    input  logic                            arst_n,

    // SoC request port
    input  logic                            soc_dv,
    input  logic [mci_pkg::ADDR_WIDTH-1:0]  soc_addr,
    input  logic                            soc_write,
    input  logic [mci_pkg::DATA_WIDTH-1:0]  soc_wdata,
    input  logic [mci_pkg::USER_WIDTH-1:0]  soc_user,
    output logic [mci_pkg::DATA_WIDTH-1:0]  soc_rdata,
    output logic                            soc_hold,
    output logic                            soc_error,

    // Static straps
    input  logic [mci_pkg::USER_WIDTH-1:0]  strap_mcu_lsu_axi_user,
    input  logic [mci_pkg::USER_WIDTH-1:0]  strap_mcu_ifu_axi_user,
    input  logic [mci_pkg::USER_WIDTH-1:0]  strap_mcu_sram_config_axi_user,
    input  logic [mci_pkg::USER_WIDTH-1:0]  strap_mci_soc_config_axi_user,

    // Privilege flags
    output logic                            axi_mcu_req,
    output logic                            axi_mci_soc_config_req,
    output logic                            axi_mcu_sram_config_req
);

    // Memory depths in words
    localparam int MBOX_DEPTH_WORDS = MBOX_SIZE_KB * mci_pkg::KB / (mci_pkg::DATA_WIDTH / 8);
    localparam int SRAM_DEPTH_WORDS = SRAM_SIZE_KB * mci_pkg::KB / (mci_pkg::DATA_WIDTH / 8);

    logic                           reg_dv;
    logic                           mbox_dv;
    logic                           sram_dv;
    logic [mci_pkg::ADDR_WIDTH-1:0] tgt_addr;
    logic                           tgt_write;
    logic [mci_pkg::DATA_WIDTH-1:0] tgt_wdata;
    logic                           reg_wr_priv;
    logic                           mbox_wr_priv;
    logic                           sram_wr_priv;
    logic                           req_miss;
    logic [mci_pkg::DATA_WIDTH-1:0] reg_rdata;
    logic                           reg_hold;
    logic                           reg_error;
    logic [mci_pkg::DATA_WIDTH-1:0] mbox_rdata;
    logic                           mbox_hold;
    logic                           mbox_error;
    logic [mci_pkg::DATA_WIDTH-1:0] sram_rdata;
    logic                           sram_hold;
    logic                           sram_error;
    logic                           sram_wr_lock;

    ////////////////////////////////////////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////////////////////////////////////////
    mci_sub_decode #(
        .MBOX_SIZE_KB (MBOX_SIZE_KB),
        .SRAM_SIZE_KB (SRAM_SIZE_KB)
    ) decode (
        .clk, .arst_n,
        .soc_dv, .soc_addr, .soc_write, .soc_wdata, .soc_user,
        .soc_rdata, .soc_hold, .soc_error,
        .strap_mcu_lsu_axi_user, .strap_mcu_ifu_axi_user,
        .strap_mcu_sram_config_axi_user, .strap_mci_soc_config_axi_user,
        .reg_rdata, .reg_hold, .reg_error,
        .mbox_rdata, .mbox_hold, .mbox_error,
        .sram_rdata, .sram_hold, .sram_error,
        .reg_dv, .mbox_dv, .sram_dv,
        .tgt_addr, .tgt_write, .tgt_wdata,
        .reg_wr_priv, .mbox_wr_priv, .sram_wr_priv, .req_miss,
        .axi_mcu_req, .axi_mci_soc_config_req, .axi_mcu_sram_config_req
    );

    ////////////////////////////////////////////////////////////////////////////
    // Targets
    ////////////////////////////////////////////////////////////////////////////
    mci_ctrl_regs ctrl_regs (
        .clk, .arst_n,
        .dv (reg_dv), .addr (tgt_addr), .write (tgt_write), .wdata (tgt_wdata),
        .wr_priv (reg_wr_priv), .req_miss,
        .rdata (reg_rdata), .hold (reg_hold), .error (reg_error),
        .sram_wr_lock
    );

    // Mailbox ignores the lock
    mci_sub_mem #(.DEPTH_WORDS (MBOX_DEPTH_WORDS), .LOCKABLE (1'b0)) mbox_mem (
        .clk, .arst_n,
        .dv (mbox_dv), .addr (tgt_addr), .write (tgt_write), .wdata (tgt_wdata),
        .wr_priv (mbox_wr_priv), .wr_lock (sram_wr_lock),
        .rdata (mbox_rdata), .hold (mbox_hold), .error (mbox_error)
    );

    mci_sub_mem #(.DEPTH_WORDS (SRAM_DEPTH_WORDS), .LOCKABLE (1'b1)) sram_mem (
        .clk, .arst_n,
        .dv (sram_dv), .addr (tgt_addr), .write (tgt_write), .wdata (tgt_wdata),
        .wr_priv (sram_wr_priv), .wr_lock (sram_wr_lock),
        .rdata (sram_rdata), .hold (sram_hold), .error (sram_error)
    );

endmodule

/* test/mci_sub_tb.sv */
module mci_sub_tb;

    localparam int    MBOX_SIZE_KB = 16;
    localparam int    SRAM_SIZE_KB = 64;
    localparam int    CLK_PERIOD   = 4;
    localparam int    RESET_CYCLES = 10;
    localparam string TRACE_FILE   = "test/mci_sub_trace.txt";

    // Distinct strap values
    localparam logic [mci_pkg::USER_WIDTH-1:0] LSU_USER      = 32'h0000_1001;
    localparam logic [mci_pkg::USER_WIDTH-1:0] IFU_USER      = 32'h0000_1002;
    localparam logic [mci_pkg::USER_WIDTH-1:0] SRAM_CFG_USER = 32'h0000_2001;
    localparam logic [mci_pkg::USER_WIDTH-1:0] SOC_CFG_USER  = 32'h0000_3001;

    logic                           clk;
    logic                           arst_n;
    logic                           soc_dv;
    logic [mci_pkg::ADDR_WIDTH-1:0] soc_addr;
    logic                           soc_write;
    logic [mci_pkg::DATA_WIDTH-1:0] soc_wdata;
    logic [mci_pkg::USER_WIDTH-1:0] soc_user;
    logic [mci_pkg::DATA_WIDTH-1:0] soc_rdata;
    logic                           soc_hold;
    logic                           soc_error;
    logic [mci_pkg::USER_WIDTH-1:0] soc_cfg_strap;
    logic                           axi_mcu_req;
    logic                           axi_mci_soc_config_req;
    logic                           axi_mcu_sram_config_req;

    // Trace entries with one slot per request line
    byte                            op_q[$];
    logic [mci_pkg::ADDR_WIDTH-1:0] addr_q[$];
    logic [mci_pkg::DATA_WIDTH-1:0] wdata_q[$];
    logic [mci_pkg::USER_WIDTH-1:0] user_q[$];
    logic [mci_pkg::DATA_WIDTH-1:0] rdata_q[$];
    logic                           err_q[$];
    int                             line_q[$];
    bit                             trace_loaded = 1'b0;

    mci_sub_top #(
        .MBOX_SIZE_KB (MBOX_SIZE_KB),
        .SRAM_SIZE_KB (SRAM_SIZE_KB)
    ) uut (
        .clk, .arst_n,
        .soc_dv, .soc_addr, .soc_write, .soc_wdata, .soc_user,
        .soc_rdata, .soc_hold, .soc_error,
        .strap_mcu_lsu_axi_user         (LSU_USER),
        .strap_mcu_ifu_axi_user         (IFU_USER),
        .strap_mcu_sram_config_axi_user (SRAM_CFG_USER),
        .strap_mci_soc_config_axi_user  (soc_cfg_strap),
        .axi_mcu_req, .axi_mci_soc_config_req, .axi_mcu_sram_config_req
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////
    task automatic fail_now(input string msg);
        $display("[FAIL] time %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    // Failures that are not a wrong value
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of the memory map
    ////////////////////////////////////////////////////////////////////////////
    // Unsigned offset check covers both window bounds
    function automatic bit in_window(input logic [mci_pkg::ADDR_WIDTH-1:0] addr,
                                     input logic [mci_pkg::ADDR_WIDTH-1:0] base,
                                     input int size_bytes);
        logic [mci_pkg::ADDR_WIDTH-1:0] ofs;
        ofs = addr - base;
        return ofs < 32'(size_bytes);
    endfunction

    function automatic mci_pkg::target_e classify_addr(input logic [31:0] addr);
        if (in_window(addr, mci_pkg::REG_START_ADDR, mci_pkg::REG_SIZE_BYTES)) begin
            return mci_pkg::TGT_REG;
        end else if (in_window(addr, mci_pkg::MBOX_START_ADDR, MBOX_SIZE_KB * 1024)) begin
            return mci_pkg::TGT_MBOX;
        end else if (in_window(addr, mci_pkg::SRAM_START_ADDR, SRAM_SIZE_KB * 1024)) begin
            return mci_pkg::TGT_SRAM;
        end
        return mci_pkg::TGT_NONE;
    endfunction

    // User tag compare against the straps gated by dv
    task automatic check_flags(input int line_no);
        logic exp_soc;
        logic exp_mcu;
        logic exp_sram;
        exp_soc  = soc_dv && (((soc_user == soc_cfg_strap) && (soc_cfg_strap != '0)) ||
                              (soc_cfg_strap == '1));
        exp_mcu  = soc_dv && ((soc_user == LSU_USER) || (soc_user == IFU_USER));
        exp_sram = soc_dv && (soc_user == SRAM_CFG_USER);
        assert (axi_mci_soc_config_req == exp_soc) else fail_now($sformatf(
            "line %0d: axi_mci_soc_config_req %0b, expected %0b",
            line_no, axi_mci_soc_config_req, exp_soc));
        assert (axi_mcu_req == exp_mcu) else fail_now($sformatf(
            "line %0d: axi_mcu_req %0b, expected %0b", line_no, axi_mcu_req, exp_mcu));
        assert (axi_mcu_sram_config_req == exp_sram) else fail_now($sformatf(
            "line %0d: axi_mcu_sram_config_req %0b, expected %0b",
            line_no, axi_mcu_sram_config_req, exp_sram));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Trace loading
    ////////////////////////////////////////////////////////////////////////////
    task automatic load_trace();
        int                             fd;
        int                             code;
        int                             n;
        int                             line_no;
        string                          line;
        byte                            op;
        logic [mci_pkg::ADDR_WIDTH-1:0] a;
        logic [mci_pkg::DATA_WIDTH-1:0] w;
        logic [mci_pkg::USER_WIDTH-1:0] u;
        logic [mci_pkg::DATA_WIDTH-1:0] r;
        logic [31:0]                    e;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            abort_run({"Could not open trace file ", TRACE_FILE});
        end
        line_no = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            line_no++;
            if (code > 0 && line.len() > 1) begin
                op = line.getc(0);
                if (op == "R" || op == "W" || op == "S") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                                a, w, u, r, e);
                    if (n != 5) begin
                        abort_run($sformatf("Trace line %0d has missing fields", line_no));
                    end
                    op_q.push_back(op);
                    addr_q.push_back(a);
                    wdata_q.push_back(w);
                    user_q.push_back(u);
                    rdata_q.push_back(r);
                    err_q.push_back(e[0]);
                    line_q.push_back(line_no);
                end else if (op != "#" && op != " " && op != "\t" && op != "\r") begin
                    abort_run($sformatf("Trace line %0d has an unknown op", line_no));
                end
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            abort_run("Trace file holds no requests");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Request driving
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_request(input int idx);
        mci_pkg::target_e tgt;
        logic             is_write;
        int               holds;
        int               exp_holds;
        is_write  = (op_q[idx] == "W");
        tgt       = classify_addr(addr_q[idx]);
        // Only memory reads stall and only for one cycle
        exp_holds = (!is_write && (tgt == mci_pkg::TGT_MBOX || tgt == mci_pkg::TGT_SRAM));
        @(posedge clk);
        #1;
        soc_dv    = 1'b1;
        soc_addr  = addr_q[idx];
        soc_write = is_write;
        soc_wdata = wdata_q[idx];
        soc_user  = user_q[idx];
        holds     = 0;
        @(negedge clk);
        check_flags(line_q[idx]);
        // Fields stay put while hold is up
        while (soc_hold) begin
            holds++;
            @(negedge clk);
            check_flags(line_q[idx]);
        end
        assert (holds == exp_holds) else fail_now($sformatf(
            "line %0d: %0d hold cycles, expected %0d", line_q[idx], holds, exp_holds));
        assert (soc_error == err_q[idx]) else fail_now($sformatf(
            "line %0d: soc_error %0b, expected %0b", line_q[idx], soc_error, err_q[idx]));
        if (!is_write) begin
            assert (soc_rdata == rdata_q[idx]) else fail_now($sformatf(
                "line %0d: soc_rdata 0x%08h, expected 0x%08h",
                line_q[idx], soc_rdata, rdata_q[idx]));
        end
    endtask

    // Strap change with the port idle
    task automatic set_soc_strap(input int idx);
        @(posedge clk);
        #1;
        soc_dv        = 1'b0;
        soc_write     = 1'b0;
        soc_cfg_strap = wdata_q[idx];
        @(negedge clk);
        check_flags(line_q[idx]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        arst_n        = 1'b0;
        soc_dv        = 1'b0;
        soc_addr      = '0;
        soc_write     = 1'b0;
        soc_wdata     = '0;
        soc_user      = '0;
        soc_cfg_strap = SOC_CFG_USER;
        load_trace();
        trace_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            if (op_q[i] == "S") begin
                set_soc_strap(i);
            end else begin
                run_request(i);
            end
        end
        @(posedge clk);
        #1;
        soc_dv = 1'b0;
        repeat (2) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog with a budget of four cycles per trace line
    initial begin
        int limit_cycles;
        wait (trace_loaded);
        limit_cycles = op_q.size() * 4 + RESET_CYCLES + 100;
        repeat (limit_cycles) @(posedge clk);
        abort_run($sformatf("Timeout: trace not finished after %0d cycles", limit_cycles));
    end

endmodule

/* test/mci_sub_trace.txt */
# Columns: op addr wdata user exp_rdata exp_error (hex); rdata checked on R only
# Ops: R read, W write, S set SoC-config strap to the wdata column
R 00000000 00000000 00009999 4D434901 0
W 00000008 A5A50001 00003001 00000000 0
R 00000008 00000000 00009999 A5A50001 0
W 00000008 DEADBEEF 00009999 00000000 1
R 00000008 00000000 00009999 A5A50001 0
W 0000000C 12345678 00003001 00000000 0
R 0000000C 00000000 00001001 12345678 0
W 00000000 FFFFFFFF 00003001 00000000 1
W 00000020 11111111 00003001 00000000 1
R 00000020 00000000 00003001 00000000 1
W 00400010 CAFE0001 00001001 00000000 0
R 00400010 00000000 00009999 CAFE0001 0
W 00400014 CAFE0002 00001002 00000000 0
R 00400014 00000000 00001002 CAFE0002 0
W 00400010 BAD00BAD 00009999 00000000 1
W 00400018 0BADF00D 00002001 00000000 1
R 00400010 00000000 00001001 CAFE0001 0
W 00C00100 5A5A0001 00002001 00000000 0
R 00C00100 00000000 00002001 5A5A0001 0
W 00C00104 5A5A0002 00001001 00000000 0
W 00C00108 5A5A0003 00003001 00000000 1
W 00000004 00000001 00003001 00000000 0
R 00000004 00000000 00009999 00000001 0
W 00C00100 77777777 00002001 00000000 1
W 00C00104 77777777 00001001 00000000 1
R 00C00100 00000000 00002001 5A5A0001 0
R 00C00104 00000000 00001001 5A5A0002 0
W 00000004 00000000 00003001 00000000 0
W 00C00100 5A5A00FF 00002001 00000000 0
R 00C00100 00000000 00002001 5A5A00FF 0
R 00001000 00000000 00009999 00000000 0
W 00404000 44444444 00001001 00000000 0
R 00800000 00000000 00003001 00000000 0
R 00C10000 00000000 00002001 00000000 0
R 00000010 00000000 00009999 00000004 0
W 00000010 00000000 00003001 00000000 1
S 00000000 FFFFFFFF 00000000 00000000 0
W 00000008 13572468 00009999 00000000 0
R 00000008 00000000 00009999 13572468 0
W 0000000C 24681357 00001001 00000000 0
R 0000000C 00000000 00002001 24681357 0
S 00000000 00000000 00000000 00000000 0
W 00000008 99999999 00000000 00000000 1
R 00000008 00000000 00000000 13572468 0
R 00000010 00000000 00000000 00000004 0

/* all.f */
hw/mci_pkg.sv
hw/mci_sub_decode.sv
hw/mci_ctrl_regs.sv
hw/mci_sub_mem.sv
hw/mci_sub_top.sv
test/mci_sub_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the mci_sub testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=mci_sub_sim

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module mci_sub_tb --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("./$BUILD_DIR/$SIM_BIN" 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi
